//--- heartHud.f
logic/hudPkg.sv
logic/rasterScan.sv
logic/livesTracker.sv
logic/heartRenderer.sv
logic/hudCompose.sv
logic/heartHud.sv
tests/hudChecker.sv
tests/heartHudTb.sv

//--- tests/heartStimulus.txt
// frame, command (0 none, 1 hit, 2 restart), probe x, probe y, expected rgb, expected lives
// all hex, records in frame order and raster order within a frame
00 0 064 064 003 3
00 0 14A 064 000 3
00 0 10E 098 F00 3
00 0 10E 0D4 F00 3
00 0 064 0F2 000 3
01 1 10F 095 F00 3
01 0 10F 0B3 F00 3
02 0 032 032 300 2
02 0 10E 08D F00 2
02 0 10F 095 300 2
02 0 10E 096 300 2
02 0 10F 0B3 F00 2
03 0 064 064 300 2
05 0 064 064 300 2
05 0 10F 095 300 2
06 1 064 064 003 2
06 0 10F 095 003 2
07 1 10F 095 300 1
07 0 10F 0B3 300 1
07 0 10C 0B7 300 1
07 0 107 0BD F00 1
07 0 10F 0D1 F00 1
08 1 10E 0C8 F00 0
08 0 10F 0D1 300 0
08 0 10E 0D8 F00 0
08 0 110 0D8 300 0
08 0 109 0DC F00 0
09 0 10F 0D1 300 0
0B 0 064 064 300 0
0C 1 064 064 003 0
0C 2 10F 0D1 003 0
0D 1 064 064 003 3
0D 0 10F 095 F00 3
0D 0 10F 0B3 F00 3
0D 0 10C 0B7 F00 3
0D 0 10F 0D1 F00 3
0E 2 064 064 300 2
0E 0 10F 095 300 2
0F 0 064 064 300 3
0F 0 10F 095 F00 3
0F 0 14A 0C8 000 3

//--- tests/heartHudTb.sv
`timescale 1ns/100ps

module heartHudTb;

  localparam int maxRecords  = 64;
  localparam int fieldCount  = 6;          // frame, command, x, y, rgb, lives
  localparam int frameCycles = 400 * 262;  // one full scan

  logic             clk = 1'b0;
  logic             nrst;
  logic             hit;
  logic             restart;
  hudPkg::pixelOutT pixel;
  hudPkg::livesT    lives;
  logic             gameOver;

  logic [15:0] stimMem [maxRecords*fieldCount];
  int          numRecords;
  int          lastFrame;
  int          cycleLimit;
  int          cycles;
  int          scanIdx;       // scan position that sees the next driven input
  int          frameCount;
  int          rgbErrors;
  int          syncErrors;
  int          livesErrors;
  int          missedProbes;

  always #5 clk = ~clk;

  heartHud DUT (
    .clk     (clk),
    .nrst    (nrst),
    .hit     (hit),
    .restart (restart),
    .pixel   (pixel),
    .lives   (lives),
    .gameOver(gameOver)
  );

  hudChecker #(.maxRecords(maxRecords)) hudCheck (
    .clk         (clk),
    .nrst        (nrst),
    .pixel       (pixel),
    .lives       (lives),
    .gameOver    (gameOver),
    .stim        (stimMem),
    .numRecords  (numRecords),
    .frameCount  (frameCount),
    .rgbErrors   (rgbErrors),
    .syncErrors  (syncErrors),
    .livesErrors (livesErrors),
    .missedProbes(missedProbes)
  );

  task automatic loadStimulus();
    for (int i = 0; i < maxRecords * fieldCount; i++) begin
      stimMem[i] = 16'hFFFF;  // marks the end of the records
    end
    $readmemh("tests/heartStimulus.txt", stimMem);
    numRecords = 0;
    lastFrame  = 0;
    while (numRecords < maxRecords && stimMem[numRecords*fieldCount] != 16'hFFFF) begin
      if (int'(stimMem[numRecords*fieldCount]) > lastFrame) begin
        lastFrame = int'(stimMem[numRecords*fieldCount]);
      end
      numRecords++;
    end
  endtask

  // one pulse per command somewhere in rows 1 to 239 of its frame
  task automatic driveCommands();
    int          target;
    logic [15:0] cmd;
    for (int r = 0; r < numRecords; r++) begin
      cmd = stimMem[r*fieldCount + 1];
      if (cmd != 16'h0) begin
        target = int'(stimMem[r*fieldCount]) * frameCycles
               + int'(1 + $urandom % 239) * 400 + int'($urandom % 400);
        if (target <= scanIdx) begin
          target = scanIdx + 1;  // keeps two pulses in one frame apart
        end
        repeat (target - scanIdx) @(posedge clk);
        if (cmd == 16'h1) begin
          hit <= 1'b1;
        end else begin
          restart <= 1'b1;
        end
        @(posedge clk);
        hit     <= 1'b0;
        restart <= 1'b0;
        scanIdx = target + 1;
      end
    end
  endtask

  task automatic reportCounts();
    $display("errors: rgb %0d, sync %0d, lives %0d, missed probes %0d",
             rgbErrors, syncErrors, livesErrors, missedProbes);
  endtask

  initial begin
    hit        = 1'b0;
    restart    = 1'b0;
    nrst       = 1'b0;
    cycles     = 0;
    void'($urandom(32'h2ab5));
    loadStimulus();
    cycleLimit = (lastFrame + 2) * frameCycles;
    repeat (8) @(posedge clk);
    nrst <= 1'b1;
    scanIdx = 0;
    driveCommands();
    while (frameCount <= lastFrame) @(posedge clk);
    reportCounts();
    if (rgbErrors + syncErrors + livesErrors + missedProbes == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  always @(posedge clk) begin
    if (nrst === 1'b1) begin
      cycles <= cycles + 1;
      if (cycles >= cycleLimit) begin
        $display("timeout: frame %0d did not finish within %0d cycles", lastFrame, cycleLimit);
        reportCounts();
        $display("Done: errors found");
        $finish;
      end
    end
  end

endmodule

//--- tests/hudChecker.sv
`timescale 1ns/100ps

module hudChecker #(
  parameter int maxRecords = 64
) (
  input  logic             clk,
  input  logic             nrst,
  input  hudPkg::pixelOutT pixel,
  input  hudPkg::livesT    lives,
  input  logic             gameOver,
  input  logic [15:0]      stim [maxRecords*6],
  input  int               numRecords,
  output int               frameCount,
  output int               rgbErrors,
  output int               syncErrors,
  output int               livesErrors,
  output int               missedProbes
);

  localparam int fieldCount = 6;

  logic running;    // pixel holds a real scan position
  logic prevVsync;
  int   probeIdx;   // probes are stored in frame and raster order

  function automatic logic [15:0] stimField(input int rec, input int col);
    return stim[rec*fieldCount + col];
  endfunction

  task automatic checkFlag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("FAILED t=%0t %s expected %b got %b at (%0d, %0d)",
               $time, name, expected, actual, pixel.x, pixel.y);
      syncErrors++;
    end
  endtask

  // sampled on the falling edge, away from the DUT updates
  always @(negedge clk) begin
    logic [11:0] expRgb;
    logic [1:0]  expLives;
    if (nrst !== 1'b1) begin
      running      = 1'b0;
      prevVsync    = 1'b0;
      probeIdx     = 0;
      frameCount   = 0;
      rgbErrors    = 0;
      syncErrors   = 0;
      livesErrors  = 0;
      missedProbes = 0;
    end else if (!running) begin
      running = 1'b1;  // pixel still shows its reset value
    end else begin
      if (prevVsync && !pixel.vsync) begin
        frameCount++;  // counted off the vsync tail
      end
      prevVsync = pixel.vsync;

      checkFlag("pixel.active", (pixel.x < 320) && (pixel.y < 240), pixel.active);
      checkFlag("pixel.hsync", (pixel.x >= 336) && (pixel.x <= 367), pixel.hsync);
      checkFlag("pixel.vsync", (pixel.y >= 244) && (pixel.y <= 245), pixel.vsync);
      if (!pixel.active && pixel.rgb !== 12'h000) begin
        $display("FAILED t=%0t pixel.rgb expected 000 got %h at blank (%0d, %0d)",
                 $time, pixel.rgb, pixel.x, pixel.y);
        rgbErrors++;
      end

      while (probeIdx < numRecords && int'(stimField(probeIdx, 0)) < frameCount) begin
        $display("probe at (%0d, %0d) in frame %0d never showed up on the pixel output",
                 stimField(probeIdx, 2), stimField(probeIdx, 3), stimField(probeIdx, 0));
        missedProbes++;
        probeIdx++;
      end

      if (probeIdx < numRecords && int'(stimField(probeIdx, 0)) == frameCount
          && stimField(probeIdx, 2) == 16'(pixel.x)
          && stimField(probeIdx, 3) == 16'(pixel.y)) begin
        expRgb   = 12'(stimField(probeIdx, 4));
        expLives = 2'(stimField(probeIdx, 5));
        if (pixel.rgb !== expRgb) begin
          $display("FAILED t=%0t pixel.rgb expected %h got %h at (%0d, %0d) frame %0d",
                   $time, expRgb, pixel.rgb, pixel.x, pixel.y, frameCount);
          rgbErrors++;
        end
        if (lives !== expLives) begin
          $display("FAILED t=%0t lives expected %0d got %0d in frame %0d",
                   $time, expLives, lives, frameCount);
          livesErrors++;
        end
        if (gameOver !== (expLives == 2'd0)) begin
          $display("FAILED t=%0t gameOver expected %b got %b in frame %0d",
                   $time, expLives == 2'd0, gameOver, frameCount);
          livesErrors++;
        end
        probeIdx++;
      end
    end
  end

endmodule

//--- logic/heartHud.sv
`timescale 1ns/100ps

module heartHud #(
  parameter int hActive     = 320,
  parameter int hTotal      = 400,
  parameter int vActive     = 240,
  parameter int vTotal      = 262,
  parameter int heartCol    = 260,
  parameter int heartRow    = 200,
  parameter int heartGap    = 30,
  parameter int flashFrames = 4
) (
  input  logic             clk,
  input  logic             nrst,
  input  logic             hit,
  input  logic             restart,
  output hudPkg::pixelOutT pixel,
  output hudPkg::livesT    lives,
  output logic             gameOver
);

  hudPkg::scanPosT scanPos;
  logic            hitTaken;    // pulse at the frame a hit lands
  logic            heartPixel;  // one cycle behind scanPos

  rasterScan #(
    .hActive(hActive),
    .hTotal (hTotal),
    .vActive(vActive),
    .vTotal (vTotal)
  ) scan (
    .clk    (clk),
    .nrst   (nrst),
    .scanPos(scanPos)
  );

  livesTracker tracker (
    .clk     (clk),
    .nrst    (nrst),
    .hit     (hit),
    .restart (restart),
    .scanPos (scanPos),
    .lives   (lives),
    .hitTaken(hitTaken),
    .gameOver(gameOver)
  );

  heartRenderer #(
    .heartCol(heartCol),
    .heartRow(heartRow),
    .heartGap(heartGap)
  ) render (
    .clk       (clk),
    .nrst      (nrst),
    .scanPos   (scanPos),
    .lives     (lives),
    .heartPixel(heartPixel)
  );

  hudCompose #(
    .hActive    (hActive),
    .hTotal     (hTotal),
    .vActive    (vActive),
    .vTotal     (vTotal),
    .flashFrames(flashFrames)
  ) compose (
    .clk       (clk),
    .nrst      (nrst),
    .scanPos   (scanPos),
    .heartPixel(heartPixel),
    .hitTaken  (hitTaken),
    .pixel     (pixel)
  );

endmodule

//--- logic/hudCompose.sv
`timescale 1ns/100ps

module hudCompose #(
  parameter int hActive     = 320,
  parameter int hTotal      = 400,
  parameter int vActive     = 240,
  parameter int vTotal      = 262,
  parameter int flashFrames = 4
) (
  input  logic             clk,
  input  logic             nrst,
  input  hudPkg::scanPosT  scanPos,
  input  logic             heartPixel,
  input  logic             hitTaken,
  output hudPkg::pixelOutT pixel
);

  localparam int flashW = $clog2(flashFrames + 1);

  localparam logic [11:0] black    = 12'h000;
  localparam logic [11:0] heartRed = 12'hF00;
  localparam logic [11:0] normalBg = 12'h003;  // dark blue
  localparam logic [11:0] flashBg  = 12'h300;  // dark red after a hit

  hudPkg::scanPosT   posD;     // lines up with heartPixel
  logic [flashW-1:0] flashCnt; // frames of tint left
  logic [11:0]       rgbNext;

  always_ff @(posedge clk) begin
    posD <= scanPos;
  end

  // hitTaken and the countdown both land on the blank last pixel
  always_ff @(posedge clk) begin
    if (!nrst) begin
      flashCnt <= '0;
    end else if (hitTaken) begin
      flashCnt <= flashW'(flashFrames);
    end else if (scanPos.frameStart && (flashCnt != '0)) begin
      flashCnt <= flashCnt - 1'b1;
    end
  end

  always_comb begin
    if (!posD.active) begin
      rgbNext = black;
    end else if (heartPixel) begin
      rgbNext = heartRed;
    end else if (flashCnt != '0) begin
      rgbNext = flashBg;
    end else begin
      rgbNext = normalBg;
    end
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      pixel <= '0;
    end else begin
      pixel.x      <= posD.x;
      pixel.y      <= posD.y;
      pixel.active <= posD.active;
      pixel.hsync  <= posD.hsync;
      pixel.vsync  <= posD.vsync;
      pixel.rgb    <= rgbNext;
    end
  end

  // nothing is painted outside the active window of the scan
  blankOutside: assert property (@(posedge clk) disable iff (!nrst)
    (!pixel.active || pixel.x >= 9'(hActive) || pixel.y >= 9'(vActive))
      |-> (pixel.rgb == black))
    else $error("rgb %h painted at blank position (%0d, %0d)", pixel.rgb, pixel.x, pixel.y);

  // flash countdown must run while the delayed stage is on the last pixel
  frameAlign: assert property (@(posedge clk) disable iff (!nrst)
    (scanPos.frameStart && $past(nrst))
      |-> (posD.x == 9'(hTotal - 1)) && (posD.y == 9'(vTotal - 1)))
    else $error("delayed position out of step with frame start");

endmodule

//--- logic/heartRenderer.sv
`timescale 1ns/100ps

module heartRenderer #(
  parameter int heartCol = 260,
  parameter int heartRow = 200,
  parameter int heartGap = 30
) (
  input  logic            clk,
  input  logic            nrst,
  input  hudPkg::scanPosT scanPos,
  input  hudPkg::livesT   lives,
  output logic            heartPixel
);

  localparam int numHearts = 3;

  logic [numHearts-1:0] onHeart;  // position lit by heart k
  logic                 heartDetect;

  // heart 0 sits lowest, each next one heartGap rows higher
  for (genvar k = 0; k < numHearts; k++) begin : gHeart
    localparam int topRow = heartRow - k * heartGap;

    logic [9:0]        dx;       // column offset into the sprite
    logic [9:0]        dy;       // row offset into the sprite
    logic              inBox;
    logic              cracked;
    hudPkg::heartLineT maskLine;

    // left of or above the box wraps to a large value
    assign dx = {1'b0, scanPos.x} - 10'(heartCol);
    assign dy = {1'b0, scanPos.y} - 10'(topRow);

    assign inBox = (dx < 10'(hudPkg::heartRows)) && (dy < 10'(hudPkg::heartRows));

    // lost lives crack hearts from the top down
    assign cracked = (2'(k) >= lives);

    always_comb begin
      if (!inBox) begin
        maskLine = '0;
      end else if (cracked) begin
        maskLine = hudPkg::heartCrackMask[dy[4:0]];
      end else begin
        maskLine = hudPkg::heartWholeMask[dy[4:0]];
      end
    end

    assign onHeart[k] = inBox & maskLine[dx[4:0]];  // column index only valid in the box
  end

  assign heartDetect = |onHeart;  // boxes never overlap

  always_ff @(posedge clk) begin
    if (!nrst) begin
      heartPixel <= 1'b0;
    end else begin
      heartPixel <= heartDetect;  // one cycle behind scanPos
    end
  end

endmodule

//--- logic/livesTracker.sv
`timescale 1ns/100ps

module livesTracker (
  input  logic            clk,
  input  logic            nrst,
  input  logic            hit,
  input  logic            restart,
  input  hudPkg::scanPosT scanPos,
  output hudPkg::livesT   lives,
  output logic            hitTaken,
  output logic            gameOver
);

  localparam hudPkg::livesT fullLives = 2'd3;

  logic hitPend;      // hit seen during this frame
  logic restartPend;
  logic hitNow;       // pending or arriving this cycle
  logic restartNow;

  assign hitNow     = hitPend | hit;
  assign restartNow = restartPend | restart;

  // restart wins, and a hit at zero lives is swallowed
  assign hitTaken = scanPos.frameStart & hitNow & ~restartNow & (lives != 2'd0);
  assign gameOver = (lives == 2'd0);

  always_ff @(posedge clk) begin
    if (!nrst) begin
      lives       <= fullLives;
      hitPend     <= 1'b0;
      restartPend <= 1'b0;
    end else if (scanPos.frameStart) begin
      hitPend     <= 1'b0;  // consumed at the frame boundary
      restartPend <= 1'b0;
      if (restartNow) begin
        lives <= fullLives;
      end else if (hitTaken) begin
        lives <= lives - 2'd1;
      end
    end else begin
      hitPend     <= hitNow;
      restartPend <= restartNow;
    end
  end

  // a taken hit only ever lands on scan position (0, 0)
  hitAtFrame: assert property (@(posedge clk) disable iff (!nrst)
    hitTaken |-> (scanPos.x == '0) && (scanPos.y == '0))
    else $error("hitTaken away from scan position (0, 0)");

endmodule

//--- logic/rasterScan.sv
`timescale 1ns/100ps

module rasterScan #(
  parameter int hActive = 320,
  parameter int hTotal  = 400,
  parameter int vActive = 240,
  parameter int vTotal  = 262
) (
  input  logic            clk,
  input  logic            nrst,
  output hudPkg::scanPosT scanPos
);

  localparam int hSyncStart = hActive + 16;  // column 336
  localparam int hSyncEnd   = hSyncStart + 32;  // first column past the pulse
  localparam int vSyncStart = vActive + 4;   // row 244
  localparam int vSyncEnd   = vSyncStart + 2;

  logic [8:0] col;
  logic [8:0] row;
  logic       lineEnd;   // last column of a line
  logic       frameEnd;  // last row of a frame

  assign lineEnd  = (col == 9'(hTotal - 1));
  assign frameEnd = (row == 9'(vTotal - 1));

  always_ff @(posedge clk) begin
    if (!nrst) begin
      col <= '0;
      row <= '0;
    end else if (lineEnd) begin
      col <= '0;
      if (frameEnd) begin
        row <= '0;
      end else begin
        row <= row + 9'd1;
      end
    end else begin
      col <= col + 9'd1;
    end
  end

  // flags follow straight from the counters
  always_comb begin
    scanPos.x          = col;
    scanPos.y          = row;
    scanPos.active     = (col < 9'(hActive)) && (row < 9'(vActive));
    scanPos.hsync      = (col >= 9'(hSyncStart)) && (col < 9'(hSyncEnd));
    scanPos.vsync      = (row >= 9'(vSyncStart)) && (row < 9'(vSyncEnd));
    scanPos.frameStart = (col == '0) && (row == '0);
  end

  scanInRange: assert property (@(posedge clk) disable iff (!nrst)
    (col < 9'(hTotal)) && (row < 9'(vTotal)))
    else $error("scan position left the %0d x %0d raster", hTotal, vTotal);

endmodule

//--- logic/hudPkg.sv
package hudPkg;

  typedef logic [1:0] livesT;  // remaining lives, 0 to 3

  // one scan position with its timing flags
  typedef struct packed {
    logic [8:0] x;          // column
    logic [8:0] y;          // row 0 to 261
    logic       active;     // inside 320 x 240
    logic       hsync;
    logic       vsync;
    logic       frameStart; // only at (0, 0)
  } scanPosT;

  typedef struct packed {
    logic [8:0]  x;
    logic [8:0]  y;
    logic        active;
    logic        hsync;
    logic        vsync;
    logic [11:0] rgb;       // 4 bits per channel
  } pixelOutT;

  localparam int heartRows = 21;  // square sprite so rows equal columns

  typedef logic [heartRows-1:0] heartLineT;  // bit c lights column c

  localparam heartLineT heartWholeMask [heartRows] = '{
    21'b000000000010000000000,  // tip of the top point
    21'b000000000111000000000,
    21'b000000001111100000000,
    21'b000000011111110000000,
    21'b000000111111111000000,
    21'b000001111111111100000,
    21'b000011111111111110000,
    21'b000111111111111111000,
    21'b001111111111111111100,
    21'b011111111111111111110,
    21'b011111111111111111110,
    21'b111111111111111111111,  // widest band
    21'b111111111111111111111,
    21'b111111111111111111111,
    21'b111111111111111111111,
    21'b111111111111111111111,
    21'b011111111111111111110,
    21'b011111111111111111110,
    21'b001111111101111111100,  // lobes start to split
    21'b000111111000111111000,
    21'b000001110000011100000
  };

  // same outline with a zigzag gap down rows 9 to 18
  localparam heartLineT heartCrackMask [heartRows] = '{
    21'b000000000010000000000,
    21'b000000000111000000000,
    21'b000000001111100000000,
    21'b000000011111110000000,
    21'b000000111111111000000,
    21'b000001111111111100000,
    21'b000011111111111110000,
    21'b000111111111111111000,
    21'b001111111111111111100,
    21'b011111111011111111110,  // gap at 11
    21'b011111111001111111110,
    21'b111111111101111111111,
    21'b111111111100111111111,
    21'b111111111110011111111,  // crack leans furthest at 8-9
    21'b111111111100111111111,
    21'b111111111001111111111,
    21'b011111110011111111110,
    21'b011111111001111111110,
    21'b001111111100111111100,
    21'b000111111000111111000,
    21'b000001110000011100000
  };

endpackage
